// File: slot_cmd_pkg.sv
package slot_cmd_pkg;

    // Width of one command byte and of the hardware control word
    localparam int CTL_WIDTH = 8;

    // Control word loaded at reset, suits the PCM1804 defaults
    localparam logic [CTL_WIDTH-1:0] HWCON_DEFAULT = 8'h51;

    // First byte of each command
    typedef enum logic [CTL_WIDTH-1:0] {
        CMD_START_RECORDING = 8'h03,
        CMD_STOP_RECORDING  = 8'h04,
        CMD_SET_ACON        = 8'h05
    } slot_opcode_t;

    // Decoder position within a command
    typedef enum logic {
        DEC_OPCODE   = 1'b0,
        // Next byte is the new hwcon value
        DEC_ACON_ARG = 1'b1
    } decode_state_t;

endpackage

// File: i2s_pkg.sv
package i2s_pkg;

    // Bits captured per channel in each half frame
    localparam int SAMPLE_BITS = 24;

    // Output word, sample right aligned and zero extended
    localparam int WORD_BITS = 32;

    // Sample FIFO size and the width needed to count 0 to FIFO_DEPTH
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_COUNT_BITS = 5;

    // Bit position counter inside one LRCK half
    localparam int BIT_COUNT_BITS = 6;

    // Channel being shifted in
    typedef enum logic {
        PHASE_LEFT  = 1'b0,
        PHASE_RIGHT = 1'b1
    } capture_phase_t;

endpackage

// File: slot_cmd_decode.sv
module slot_cmd_decode (
    input  logic                               adc_pbck,
    input  logic                               reset,
    input  logic                               ctl_valid,
    input  logic [slot_cmd_pkg::CTL_WIDTH-1:0] ctl_data,
    output logic                               recording,
    output logic [slot_cmd_pkg::CTL_WIDTH-1:0] hwcon
);

    slot_cmd_pkg::decode_state_t state;

    // One byte per strobe, no back-pressure on the command side
    always_ff @(posedge adc_pbck) begin
        if (reset) begin
            state     <= slot_cmd_pkg::DEC_OPCODE;
            recording <= 1'b0;
            hwcon     <= slot_cmd_pkg::HWCON_DEFAULT;
        end else if (ctl_valid) begin
            case (state)
                slot_cmd_pkg::DEC_OPCODE: begin
                    case (ctl_data)
                        slot_cmd_pkg::CMD_START_RECORDING: begin
                            recording <= 1'b1;
                        end
                        slot_cmd_pkg::CMD_STOP_RECORDING: begin
                            recording <= 1'b0;
                        end
                        slot_cmd_pkg::CMD_SET_ACON: begin
                            // Argument byte follows
                            state <= slot_cmd_pkg::DEC_ACON_ARG;
                        end
                        default: begin
                            // Unknown first byte is dropped
                            state <= slot_cmd_pkg::DEC_OPCODE;
                        end
                    endcase
                end
                slot_cmd_pkg::DEC_ACON_ARG: begin
                    hwcon <= ctl_data;
                    state <= slot_cmd_pkg::DEC_OPCODE;
                end
                default: begin
                    state <= slot_cmd_pkg::DEC_OPCODE;
                end
            endcase
        end
    end

endmodule

// File: i2s_capture.sv
module i2s_capture (
    input  logic                          adc_pbck,
    input  logic                          reset,
    input  logic                          adc_plrck,
    input  logic                          adc_sdata,
    input  logic                          recording,
    input  logic                          fifo_en,
    output logic                          word_valid,
    output logic [i2s_pkg::WORD_BITS-1:0] word_data
);

    logic                              lrck_last;
    logic                              lrck_rise;
    logic                              lrck_fall;
    logic                              shifting;
    logic [1:0]                        enable_dly;
    logic                              record_active;
    i2s_pkg::capture_phase_t           phase;
    logic [i2s_pkg::BIT_COUNT_BITS-1:0] bit_count;
    logic [i2s_pkg::SAMPLE_BITS-1:0]   left_sample;
    logic [i2s_pkg::SAMPLE_BITS-1:0]   right_sample;

    // Edge is seen in the first cycle LRCK shows its new level
    assign lrck_rise = adc_plrck && !lrck_last;
    assign lrck_fall = !adc_plrck && lrck_last;

    // MSB arrives one bit clock after the LRCK change
    assign shifting = !lrck_rise && !lrck_fall && (bit_count < i2s_pkg::SAMPLE_BITS);

    // Control state
    always_ff @(posedge adc_pbck) begin
        if (reset) begin
            lrck_last     <= 1'b0;
            enable_dly    <= 2'b00;
            record_active <= 1'b0;
            phase         <= i2s_pkg::PHASE_LEFT;
            bit_count     <= '0;
            word_valid    <= 1'b0;
        end else begin
            lrck_last  <= adc_plrck;
            // Two stage delay on the record permission
            enable_dly <= {enable_dly[0], recording && fifo_en};
            word_valid <= 1'b0;

            if (lrck_fall) begin
                // Right word uses the permission of the pair it closes
                word_valid    <= record_active;
                record_active <= enable_dly[1];
                phase         <= i2s_pkg::PHASE_LEFT;
                bit_count     <= '0;
            end else if (lrck_rise) begin
                word_valid <= record_active;
                phase      <= i2s_pkg::PHASE_RIGHT;
                bit_count  <= '0;
            end else if (shifting) begin
                bit_count <= bit_count + 1'b1;
            end
        end
    end

    // Sample shift registers and output word
    always_ff @(posedge adc_pbck) begin
        if (shifting && (phase == i2s_pkg::PHASE_LEFT)) begin
            left_sample <= {left_sample[i2s_pkg::SAMPLE_BITS-2:0], adc_sdata};
        end
        if (shifting && (phase == i2s_pkg::PHASE_RIGHT)) begin
            right_sample <= {right_sample[i2s_pkg::SAMPLE_BITS-2:0], adc_sdata};
        end

        // Finished sample of the other channel, zero extended
        if (lrck_rise) begin
            word_data <= {{(i2s_pkg::WORD_BITS - i2s_pkg::SAMPLE_BITS){1'b0}}, left_sample};
        end else if (lrck_fall) begin
            word_data <= {{(i2s_pkg::WORD_BITS - i2s_pkg::SAMPLE_BITS){1'b0}}, right_sample};
        end
    end

endmodule

// File: sample_fifo.sv
module sample_fifo (
    input  logic                                adc_pbck,
    input  logic                                reset,
    input  logic                                word_valid,
    input  logic [i2s_pkg::WORD_BITS-1:0]       word_data,
    output logic                                aud_valid,
    output logic [i2s_pkg::WORD_BITS-1:0]       aud_data,
    input  logic                                aud_ready,
    output logic [i2s_pkg::FIFO_COUNT_BITS-1:0] fifo_count
);

    logic [i2s_pkg::WORD_BITS-1:0]           mem [i2s_pkg::FIFO_DEPTH];
    logic [$clog2(i2s_pkg::FIFO_DEPTH)-1:0]  wr_ptr;
    logic [$clog2(i2s_pkg::FIFO_DEPTH)-1:0]  rd_ptr;
    logic                                    full;
    logic                                    do_write;
    logic                                    do_read;

    assign full = (fifo_count == i2s_pkg::FIFO_COUNT_BITS'(i2s_pkg::FIFO_DEPTH));

    // Capture cannot stall, so a word that finds the buffer full is lost
    assign do_write = word_valid && !full;
    assign do_read  = aud_valid && aud_ready;

    assign aud_valid = (fifo_count != '0);
    assign aud_data  = mem[rd_ptr];

    // Storage
    always_ff @(posedge adc_pbck) begin
        if (do_write) begin
            mem[wr_ptr] <= word_data;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge adc_pbck) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({do_write, do_read})
                2'b10: begin
                    fifo_count <= fifo_count + 1'b1;
                end
                2'b01: begin
                    fifo_count <= fifo_count - 1'b1;
                end
                default: begin
                    // Both or neither, level unchanged
                    fifo_count <= fifo_count;
                end
            endcase
        end
    end

endmodule

// File: adc_record_top.sv
module adc_record_top (
    input  logic                                adc_pbck,
    input  logic                                reset,
    input  logic                                adc_plrck,
    input  logic                                adc_sdata,
    input  logic                                fifo_en,
    input  logic                                ctl_valid,
    input  logic [slot_cmd_pkg::CTL_WIDTH-1:0]  ctl_data,
    output logic                                aud_valid,
    output logic [i2s_pkg::WORD_BITS-1:0]       aud_data,
    input  logic                                aud_ready,
    output logic [slot_cmd_pkg::CTL_WIDTH-1:0]  hwcon,
    output logic [i2s_pkg::FIFO_COUNT_BITS-1:0] fifo_count
);

    logic                          recording;
    logic                          word_valid;
    logic [i2s_pkg::WORD_BITS-1:0] word_data;

    // Command bytes set the record flag and the converter control word
    slot_cmd_decode decode (
        .adc_pbck  (adc_pbck),
        .reset     (reset),
        .ctl_valid (ctl_valid),
        .ctl_data  (ctl_data),
        .recording (recording),
        .hwcon     (hwcon)
    );

    // I2S receiver, emits left/right word pairs
    i2s_capture execute (
        .adc_pbck   (adc_pbck),
        .reset      (reset),
        .adc_plrck  (adc_plrck),
        .adc_sdata  (adc_sdata),
        .recording  (recording),
        .fifo_en    (fifo_en),
        .word_valid (word_valid),
        .word_data  (word_data)
    );

    // Buffers captured words until the reader takes them
    sample_fifo result (
        .adc_pbck   (adc_pbck),
        .reset      (reset),
        .word_valid (word_valid),
        .word_data  (word_data),
        .aud_valid  (aud_valid),
        .aud_data   (aud_data),
        .aud_ready  (aud_ready),
        .fifo_count (fifo_count)
    );

endmodule

// File: tb_adc_record.sv
module tb_adc_record;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_CYCLES  = 32;
    localparam int FRAME_CYCLES = 2 * HALF_CYCLES;
    localparam int NUM_FRAMES   = 50;
    localparam int RESET_CYCLES = 4;
    localparam int IDLE_CYCLES  = 8;
    localparam int TAIL_CYCLES  = 40;
    // Room for the trailing half, the drain and the tail
    localparam int SLACK_CYCLES = 788;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + IDLE_CYCLES
                                  + NUM_FRAMES * FRAME_CYCLES + SLACK_CYCLES;

    // Commands start in cycles 8 to 19 so a two byte command ends by cycle 20
    localparam int CMD_FIRST = 8;
    localparam int CMD_SPAN  = 12;

    // Command choice for one half frame
    localparam int MODE_NONE   = 0;
    localparam int MODE_RANDOM = 1;
    localparam int MODE_START  = 2;
    localparam int MODE_STOP   = 3;

    logic                                adc_pbck = 1'b0;
    logic                                reset;
    logic                                adc_plrck;
    logic                                adc_sdata;
    logic                                fifo_en;
    logic                                ctl_valid;
    logic [slot_cmd_pkg::CTL_WIDTH-1:0]  ctl_data;
    logic                                aud_valid;
    logic [i2s_pkg::WORD_BITS-1:0]       aud_data;
    logic                                aud_ready;
    logic [slot_cmd_pkg::CTL_WIDTH-1:0]  hwcon;
    logic [i2s_pkg::FIFO_COUNT_BITS-1:0] fifo_count;

    integer seed = 81;
    int     cycle_count = 0;
    bit     checking = 1'b0;

    // Reference model
    logic                               model_rec;
    logic                               model_fifo_en;
    logic [slot_cmd_pkg::CTL_WIDTH-1:0] model_hwcon;
    logic                               frame_en;
    logic [i2s_pkg::SAMPLE_BITS-1:0]    left_hold;
    logic [i2s_pkg::SAMPLE_BITS-1:0]    right_hold;
    logic [i2s_pkg::WORD_BITS-1:0]      exp_q[$];

    // Output monitor
    logic                          held_valid;
    logic [i2s_pkg::WORD_BITS-1:0] held_data;
    logic [i2s_pkg::WORD_BITS-1:0] expected_word;
    int                            xfer_count;

    always #2 adc_pbck = ~adc_pbck;

    adc_record_top DUT (
        .adc_pbck   (adc_pbck),
        .reset      (reset),
        .adc_plrck  (adc_plrck),
        .adc_sdata  (adc_sdata),
        .fifo_en    (fifo_en),
        .ctl_valid  (ctl_valid),
        .ctl_data   (ctl_data),
        .aud_valid  (aud_valid),
        .aud_data   (aud_data),
        .aud_ready  (aud_ready),
        .hwcon      (hwcon),
        .fifo_count (fifo_count)
    );

    task automatic mismatch_stop(input string msg);
        $display("Mismatch at %0t: %s", $time, msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic failure_stop(input string msg);
        $display("Error at %0t: %s", $time, msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    function automatic logic [i2s_pkg::WORD_BITS-1:0] to_word(
        input logic [i2s_pkg::SAMPLE_BITS-1:0] sample
    );
        logic [i2s_pkg::WORD_BITS-1:0] w;
        w = '0;
        w[i2s_pkg::SAMPLE_BITS-1:0] = sample;
        return w;
    endfunction

    // Advance one clock, reader accepts with probability one half
    task automatic next_cycle();
        logic [31:0] r;
        @(posedge adc_pbck);
        r = $random(seed);
        aud_ready <= r[0];
    endtask

    // One LRCK half: edge at cycle 0, sample bits in cycles 1 to 24
    task automatic run_half(input logic level, input int cmd_mode);
        logic [31:0]                        r;
        logic [31:0]                        r2;
        logic [i2s_pkg::SAMPLE_BITS-1:0]    sample;
        logic [slot_cmd_pkg::CTL_WIDTH-1:0] first_byte;
        logic [slot_cmd_pkg::CTL_WIDTH-1:0] second_byte;
        logic                               next_rec;
        logic                               next_en;
        logic [slot_cmd_pkg::CTL_WIDTH-1:0] next_hwcon;
        int                                 byte_count;
        int                                 cmd_pos;
        int                                 p;
        r = $random(seed);
        sample = r[i2s_pkg::SAMPLE_BITS-1:0];
        r = $random(seed);
        r2 = $random(seed);
        cmd_pos = CMD_FIRST + int'(r[31:8] % 24'(CMD_SPAN));
        first_byte = '0;
        second_byte = '0;
        byte_count = 0;
        next_rec = model_rec;
        next_en = model_fifo_en;
        next_hwcon = model_hwcon;

        case (cmd_mode)
            MODE_START: begin
                byte_count = 1;
                first_byte = slot_cmd_pkg::CMD_START_RECORDING;
                next_rec = 1'b1;
            end
            MODE_STOP: begin
                byte_count = 1;
                first_byte = slot_cmd_pkg::CMD_STOP_RECORDING;
                next_rec = 1'b0;
            end
            MODE_RANDOM: begin
                if (r[0]) begin
                    case (r[3:1])
                        3'd0, 3'd1, 3'd2: begin
                            byte_count = 1;
                            first_byte = slot_cmd_pkg::CMD_START_RECORDING;
                            next_rec = 1'b1;
                        end
                        3'd3: begin
                            byte_count = 1;
                            first_byte = slot_cmd_pkg::CMD_STOP_RECORDING;
                            next_rec = 1'b0;
                        end
                        3'd4: begin
                            byte_count = 2;
                            first_byte = slot_cmd_pkg::CMD_SET_ACON;
                            second_byte = r2[7:0];
                            next_hwcon = r2[7:0];
                        end
                        3'd5: begin
                            // Unknown opcode, no effect expected
                            byte_count = 1;
                            first_byte = r2[15:8];
                            if (first_byte == slot_cmd_pkg::CMD_START_RECORDING ||
                                first_byte == slot_cmd_pkg::CMD_STOP_RECORDING ||
                                first_byte == slot_cmd_pkg::CMD_SET_ACON) begin
                                first_byte = 8'hF0;
                            end
                        end
                        3'd6: begin
                            next_en = 1'b1;
                        end
                        default: begin
                            next_en = 1'b0;
                        end
                    endcase
                end
            end
            default: begin
                byte_count = 0;
            end
        endcase

        for (p = 0; p < HALF_CYCLES; p++) begin
            next_cycle();
            ctl_valid <= 1'b0;
            if (p == 0) begin
                adc_plrck <= level;
                assert (hwcon == model_hwcon)
                    else mismatch_stop($sformatf("hwcon %h, expected %h", hwcon, model_hwcon));
                if (!level) begin
                    // Falling edge closes the pair and latches the enable
                    if (frame_en) begin
                        exp_q.push_back(to_word(right_hold));
                    end
                    frame_en = model_rec && model_fifo_en;
                end else if (frame_en) begin
                    exp_q.push_back(to_word(left_hold));
                end
            end
            r = $random(seed);
            if (p >= 1 && p <= i2s_pkg::SAMPLE_BITS) begin
                adc_sdata <= sample[i2s_pkg::SAMPLE_BITS - p];
            end else begin
                adc_sdata <= r[0];
            end
            if (p == cmd_pos) begin
                if (byte_count > 0) begin
                    ctl_valid <= 1'b1;
                    ctl_data  <= first_byte;
                end
                fifo_en <= next_en;
                model_rec = next_rec;
                model_fifo_en = next_en;
                model_hwcon = next_hwcon;
            end
            if (p == cmd_pos + 1 && byte_count == 2) begin
                ctl_valid <= 1'b1;
                ctl_data  <= second_byte;
            end
        end

        if (!level) begin
            left_hold = sample;
        end else begin
            right_hold = sample;
        end
    endtask

    always @(posedge adc_pbck) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Verification failed");
            $fatal(1);
        end
    end

    // Outputs are sampled at the falling edge where they are settled
    always @(negedge adc_pbck) begin
        if (checking) begin
            assert (int'(fifo_count) <= i2s_pkg::FIFO_DEPTH)
                else mismatch_stop($sformatf("fifo_count %0d above depth", fifo_count));
            if (held_valid) begin
                assert (aud_valid)
                    else mismatch_stop("aud_valid dropped before transfer");
                assert (aud_data == held_data)
                    else mismatch_stop($sformatf("aud_data %h changed from %h before transfer",
                                                 aud_data, held_data));
            end
            if (aud_valid && aud_ready) begin
                assert (exp_q.size() > 0)
                    else failure_stop("a word was transferred while none was expected");
                expected_word = exp_q.pop_front();
                assert (aud_data == expected_word)
                    else mismatch_stop($sformatf("aud_data %h, expected %h",
                                                 aud_data, expected_word));
                xfer_count++;
            end
            held_valid = aud_valid && !aud_ready;
            held_data  = aud_data;
        end
    end

    initial begin
        int frame;
        int left_mode;
        int right_mode;
        reset         = 1'b1;
        adc_plrck     = 1'b1;
        adc_sdata     = 1'b0;
        fifo_en       = 1'b1;
        ctl_valid     = 1'b0;
        ctl_data      = '0;
        aud_ready     = 1'b0;
        model_rec     = 1'b0;
        model_fifo_en = 1'b1;
        model_hwcon   = slot_cmd_pkg::HWCON_DEFAULT;
        frame_en      = 1'b0;
        left_hold     = '0;
        right_hold    = '0;
        held_valid    = 1'b0;
        held_data     = '0;
        xfer_count    = 0;

        repeat (RESET_CYCLES) next_cycle();
        reset <= 1'b0;
        checking = 1'b1;
        next_cycle();
        @(negedge adc_pbck);
        assert (!aud_valid)
            else mismatch_stop("aud_valid high after reset");
        assert (fifo_count == '0)
            else mismatch_stop($sformatf("fifo_count %0d after reset", fifo_count));
        assert (hwcon == slot_cmd_pkg::HWCON_DEFAULT)
            else mismatch_stop($sformatf("hwcon %h after reset", hwcon));

        repeat (IDLE_CYCLES) next_cycle();

        // Start in the first frame, stop two frames before the end
        for (frame = 0; frame < NUM_FRAMES; frame++) begin
            if (frame == 0) begin
                left_mode = MODE_START;
            end else if (frame == NUM_FRAMES - 2) begin
                left_mode = MODE_STOP;
            end else if (frame > NUM_FRAMES - 2) begin
                left_mode = MODE_NONE;
            end else begin
                left_mode = MODE_RANDOM;
            end
            right_mode = (frame < NUM_FRAMES - 2) ? MODE_RANDOM : MODE_NONE;
            run_half(1'b0, left_mode);
            run_half(1'b1, right_mode);
        end

        // Last falling edge releases any pending right word
        run_half(1'b0, MODE_NONE);
        while (exp_q.size() != 0) begin
            next_cycle();
        end
        repeat (TAIL_CYCLES) next_cycle();
        @(negedge adc_pbck);

        assert (fifo_count == '0 && !aud_valid)
            else mismatch_stop($sformatf("FIFO holds %0d words at the end", fifo_count));
        assert (xfer_count > 0)
            else failure_stop("no word was transferred during the run");

        $display("Verification passed");
        $finish;
    end

endmodule

// File: compile.f
slot_cmd_pkg.sv
i2s_pkg.sv
slot_cmd_decode.sv
i2s_capture.sv
sample_fifo.sv
adc_record_top.sv
tb_adc_record.sv

// File: run.sh
#!/bin/sh
# Build the record path testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_adc_record

# Exit status of the simulation is the result of the script
./obj_dir/Vtb_adc_record
